//--- hdl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int DATA_W  = 32;
    localparam int SRAM_AW = 8;                   // word address, 256 words
    localparam logic [13:0] CSR_SAVE0 = 14'h030;  // SAVE0..SAVE3 sit at 0x30..0x33

    typedef enum logic [1:0] {
        size_b = 2'd0,
        size_h = 2'd1,
        size_w = 2'd2
    } mem_size_e;

    typedef enum logic [1:0] {
        op_alu   = 2'd0,
        op_load  = 2'd1,
        op_store = 2'd2,
        op_csr   = 2'd3
    } op_kind_e;

    // operation handed over by the issue point
    typedef struct packed {
        logic [DATA_W-1:0] pc;
        op_kind_e          kind;
        mem_size_e         size;
        logic              is_unsigned;
        logic              rf_we;
        logic [4:0]        rf_waddr;
        logic [DATA_W-1:0] alu_result;    // address for loads and stores
        logic [DATA_W-1:0] rkd_value;     // store data or csr write value
        logic [13:0]       csr_num;
        logic              csr_we;
        logic [DATA_W-1:0] csr_wmask;
    } ex_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        logic              rf_we;
        logic [4:0]        rf_waddr;
        logic [DATA_W-1:0] rf_wdata;
        logic              csr_re;
        logic              csr_we;
        logic [13:0]       csr_num;
        logic [DATA_W-1:0] csr_wmask;
        logic [DATA_W-1:0] csr_wvalue;
    } mem_payload_t;

    typedef struct packed {
        logic              we;
        logic [4:0]        waddr;
        logic [DATA_W-1:0] wdata;
        logic              csr_pending;   // wdata not final, csr read still to come
    } fwd_t;

    typedef union packed {
        logic [DATA_W-1:0] word;
        logic [3:0][7:0]   bytes;
        logic [1:0][15:0]  halves;
    } load_word_u;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        logic              rf_we;
        logic [4:0]        rf_waddr;
        logic [DATA_W-1:0] rf_wdata;
    } retire_t;

endpackage

`default_nettype wire

//--- hdl/load_extract.sv
`timescale 1ns/1ns
`default_nettype none

module load_extract (
    input  wire  lsu_pkg::load_word_u  rdata,
    input  wire  [1:0]                 byte_offset,
    input  wire  lsu_pkg::mem_size_e   size,
    input  wire                        is_unsigned,
    output logic [lsu_pkg::DATA_W-1:0] value
);
    import lsu_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic        byte_sign;
    logic        half_sign;

    assign sel_byte = rdata.bytes[byte_offset];
    assign sel_half = rdata.halves[byte_offset[1]];   // offset[0] ignored, no trap here

    assign byte_sign = ~is_unsigned & sel_byte[7];
    assign half_sign = ~is_unsigned & sel_half[15];

    always_comb begin
        case (size)
            size_b: begin
                value = {{(DATA_W-8){byte_sign}}, sel_byte};
            end
            size_h: begin
                value = {{(DATA_W-16){half_sign}}, sel_half};
            end
            default: begin
                value = rdata.word;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/data_sram.sv
`timescale 1ns/1ns
`default_nettype none

module data_sram (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         en,
    input  wire  [3:0]                  we,
    input  wire  [lsu_pkg::SRAM_AW-1:0] addr,
    input  wire  [lsu_pkg::DATA_W-1:0]  wdata,
    output logic [lsu_pkg::DATA_W-1:0]  rdata
);
    import lsu_pkg::*;

    localparam int DEPTH = 1 << SRAM_AW;

    logic [DATA_W-1:0] mem [DEPTH];

    // per-byte write, no init on the array
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (we[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // read port holds its last value while en is low
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rdata <= '0;
        end else if (en) begin
            rdata <= mem[addr];   // old data on a write cycle
        end
    end

endmodule

`default_nettype wire

//--- hdl/ex_issue_stage.sv
`timescale 1ns/1ns
`default_nettype none

module ex_issue_stage (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         in_valid,
    output logic                        in_allowin,
    input  wire  lsu_pkg::ex_req_t      in_req,
    input  wire                         mem_allowin,
    output logic                        ex_to_mem_valid,
    output lsu_pkg::ex_req_t            ex_to_mem_req,
    output logic                        sram_en,
    output logic [3:0]                  sram_we,
    output logic [lsu_pkg::SRAM_AW-1:0] sram_addr,
    output logic [lsu_pkg::DATA_W-1:0]  sram_wdata
);
    import lsu_pkg::*;

    logic       ex_valid;
    ex_req_t    ex_req;
    logic       ex_ready_go;
    logic       ex_go;         // op leaves for mem at the next edge
    logic       is_store;
    logic       is_mem_op;
    logic [1:0] offset;
    logic [3:0] strobe;

    assign ex_ready_go     = 1'b1;
    assign in_allowin      = ~ex_valid | (ex_ready_go & mem_allowin);
    assign ex_to_mem_valid = ex_valid & ex_ready_go;
    assign ex_to_mem_req   = ex_req;
    assign ex_go           = ex_to_mem_valid & mem_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (in_allowin) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            ex_req <= in_req;
        end
    end

    assign is_store  = ex_req.kind == op_store;
    assign is_mem_op = is_store || ex_req.kind == op_load;
    assign offset    = ex_req.alu_result[1:0];

    // byte lanes touched by the access
    always_comb begin
        case (ex_req.size)
            size_b:  strobe = 4'b0001 << offset;
            size_h:  strobe = offset[1] ? 4'b1100 : 4'b0011;
            default: strobe = 4'b1111;
        endcase
    end

    // replicate so every lane already holds the right bits
    always_comb begin
        case (ex_req.size)
            size_b:  sram_wdata = {4{ex_req.rkd_value[7:0]}};
            size_h:  sram_wdata = {2{ex_req.rkd_value[15:0]}};
            default: sram_wdata = ex_req.rkd_value;
        endcase
    end

    assign sram_en   = ex_go & is_mem_op;
    assign sram_we   = {4{ex_go & is_store}} & strobe;
    assign sram_addr = ex_req.alu_result[SRAM_AW+1:2];

endmodule

`default_nettype wire

//--- hdl/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire                         ex_to_mem_valid,
    input  wire  lsu_pkg::ex_req_t      ex_to_mem_req,
    output logic                        mem_allowin,
    input  wire  [lsu_pkg::DATA_W-1:0]  data_sram_rdata,
    input  wire                         wb_allowin,
    output logic                        mem_to_wb_valid,
    output lsu_pkg::mem_payload_t       mem_to_wb_bus,
    output lsu_pkg::fwd_t               mem_fwd
);
    import lsu_pkg::*;

    logic              mem_valid;
    ex_req_t           mem_req;
    logic              mem_ready_go;
    load_word_u        rd_word;
    logic [DATA_W-1:0] load_value;
    logic [DATA_W-1:0] mem_rf_wdata;
    logic              mem_rf_we;
    logic              is_csr;
    logic              mem_csr_re;

    assign mem_ready_go    = 1'b1;
    assign mem_allowin     = ~mem_valid | (mem_ready_go & wb_allowin);
    assign mem_to_wb_valid = mem_valid & mem_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= ex_to_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_to_mem_valid && mem_allowin) begin
            mem_req <= ex_to_mem_req;
        end
    end

    assign rd_word = data_sram_rdata;

    load_extract u_load_extract (
        .rdata       (rd_word),
        .byte_offset (mem_req.alu_result[1:0]),
        .size        (mem_req.size),
        .is_unsigned (mem_req.is_unsigned),
        .value       (load_value)
    );

    assign is_csr       = mem_req.kind == op_csr;
    assign mem_rf_we    = mem_req.rf_we & (mem_req.kind != op_store);  // stores never write rf
    assign mem_csr_re   = is_csr & mem_req.rf_we;
    assign mem_rf_wdata = (mem_req.kind == op_load) ? load_value : mem_req.alu_result;

    always_comb begin
        mem_to_wb_bus.pc         = mem_req.pc;
        mem_to_wb_bus.rf_we      = mem_rf_we;
        mem_to_wb_bus.rf_waddr   = mem_req.rf_waddr;
        mem_to_wb_bus.rf_wdata   = mem_rf_wdata;       // replaced in wb for csr reads
        mem_to_wb_bus.csr_re     = mem_csr_re;
        mem_to_wb_bus.csr_we     = is_csr & mem_req.csr_we;
        mem_to_wb_bus.csr_num    = mem_req.csr_num;
        mem_to_wb_bus.csr_wmask  = mem_req.csr_wmask;
        mem_to_wb_bus.csr_wvalue = mem_req.rkd_value;
    end

    // bypass toward decode
    always_comb begin
        mem_fwd.we          = mem_valid & mem_rf_we;
        mem_fwd.waddr       = mem_req.rf_waddr;
        mem_fwd.wdata       = mem_rf_wdata;
        mem_fwd.csr_pending = mem_valid & mem_csr_re;
    end

endmodule

`default_nettype wire

//--- hdl/wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

module wb_stage (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire                          mem_to_wb_valid,
    input  wire  lsu_pkg::mem_payload_t  mem_to_wb_bus,
    output logic                         wb_allowin,
    output logic                         retire_valid,
    output lsu_pkg::retire_t             retire,
    input  wire                          retire_ready,
    output lsu_pkg::fwd_t                wb_fwd
);
    import lsu_pkg::*;

    logic                   wb_valid;
    mem_payload_t           wb_bus;
    logic                   wb_ready_go;
    logic                   retire_fire;
    logic [3:0][DATA_W-1:0] save_csr;     // SAVE0..SAVE3
    logic                   csr_hit;
    logic [1:0]             csr_idx;
    logic [DATA_W-1:0]      csr_old;
    logic [DATA_W-1:0]      wb_rf_wdata;

    assign wb_ready_go  = 1'b1;
    assign wb_allowin   = ~wb_valid | (wb_ready_go & retire_ready);
    assign retire_valid = wb_valid & wb_ready_go;
    assign retire_fire  = retire_valid & retire_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_to_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_to_wb_valid && wb_allowin) begin
            wb_bus <= mem_to_wb_bus;
        end
    end

    assign csr_hit = wb_bus.csr_num[13:2] == CSR_SAVE0[13:2];
    assign csr_idx = wb_bus.csr_num[1:0];
    assign csr_old = csr_hit ? save_csr[csr_idx] : '0;   // unknown csr reads zero

    always_ff @(posedge clk) begin
        if (!resetn) begin
            save_csr <= '0;
        end else if (retire_fire && wb_bus.csr_we && csr_hit) begin
            save_csr[csr_idx] <= (csr_old & ~wb_bus.csr_wmask)
                               | (wb_bus.csr_wvalue & wb_bus.csr_wmask);
        end
    end

    assign wb_rf_wdata = wb_bus.csr_re ? csr_old : wb_bus.rf_wdata;

    always_comb begin
        retire.pc       = wb_bus.pc;
        retire.rf_we    = wb_bus.rf_we;
        retire.rf_waddr = wb_bus.rf_waddr;
        retire.rf_wdata = wb_rf_wdata;
    end

    always_comb begin
        wb_fwd.we          = wb_valid & wb_bus.rf_we;
        wb_fwd.waddr       = wb_bus.rf_waddr;
        wb_fwd.wdata       = wb_rf_wdata;
        wb_fwd.csr_pending = 1'b0;    // csr value already resolved here
    end

endmodule

`default_nettype wire

//--- hdl/lsu_top.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_top (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     in_valid,
    output logic                    in_allowin,
    input  wire  lsu_pkg::ex_req_t  in_req,
    output logic                    retire_valid,
    input  wire                     retire_ready,
    output lsu_pkg::retire_t        retire,
    output lsu_pkg::fwd_t           mem_fwd,
    output lsu_pkg::fwd_t           wb_fwd
);
    import lsu_pkg::*;

    logic               ex_to_mem_valid;
    ex_req_t            ex_to_mem_req;
    logic               mem_allowin;
    logic               sram_en;
    logic [3:0]         sram_we;
    logic [SRAM_AW-1:0] sram_addr;
    logic [DATA_W-1:0]  sram_wdata;
    logic [DATA_W-1:0]  sram_rdata;
    logic               mem_to_wb_valid;
    mem_payload_t       mem_to_wb_bus;
    logic               wb_allowin;

    ex_issue_stage u_ex (
        .clk             (clk),
        .resetn          (resetn),
        .in_valid        (in_valid),
        .in_allowin      (in_allowin),
        .in_req          (in_req),
        .mem_allowin     (mem_allowin),
        .ex_to_mem_valid (ex_to_mem_valid),
        .ex_to_mem_req   (ex_to_mem_req),
        .sram_en         (sram_en),
        .sram_we         (sram_we),
        .sram_addr       (sram_addr),
        .sram_wdata      (sram_wdata)
    );

    data_sram u_dram (
        .clk    (clk),
        .resetn (resetn),
        .en     (sram_en),
        .we     (sram_we),
        .addr   (sram_addr),
        .wdata  (sram_wdata),
        .rdata  (sram_rdata)
    );

    mem_stage u_mem (
        .clk             (clk),
        .resetn          (resetn),
        .ex_to_mem_valid (ex_to_mem_valid),
        .ex_to_mem_req   (ex_to_mem_req),
        .mem_allowin     (mem_allowin),
        .data_sram_rdata (sram_rdata),
        .wb_allowin      (wb_allowin),
        .mem_to_wb_valid (mem_to_wb_valid),
        .mem_to_wb_bus   (mem_to_wb_bus),
        .mem_fwd         (mem_fwd)
    );

    wb_stage u_wb (
        .clk             (clk),
        .resetn          (resetn),
        .mem_to_wb_valid (mem_to_wb_valid),
        .mem_to_wb_bus   (mem_to_wb_bus),
        .wb_allowin      (wb_allowin),
        .retire_valid    (retire_valid),
        .retire          (retire),
        .retire_ready    (retire_ready),
        .wb_fwd          (wb_fwd)
    );

endmodule

`default_nettype wire

//--- bench/lsu_sva.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_sva #(
    parameter int PAYLOAD_W = 32
) (
    input wire                 clk,
    input wire                 resetn,
    input wire                 in_valid,
    input wire                 own_allowin,
    input wire                 out_valid,
    input wire                 out_ready,
    input wire [PAYLOAD_W-1:0] payload
);

    // stage comes out of reset empty
    assert property (@(posedge clk) !resetn |=> !out_valid)
        else $error("valid output during reset or in the first cycle after it");

    assert property (@(posedge clk) disable iff (!resetn)
        out_valid && !out_ready |=> out_valid && $stable(payload))   // held for the consumer
        else $error("output dropped or changed while the next stage refused it");

    // valid only appears after an edge where this stage took something in
    assert property (@(posedge clk) disable iff (!resetn)
        $rose(out_valid) |-> $past(in_valid && own_allowin))
        else $error("valid rose without a transfer into the stage");

endmodule

bind wb_stage lsu_sva #(.PAYLOAD_W($bits(lsu_pkg::retire_t))) u_wb_sva (
    .clk         (clk),
    .resetn      (resetn),
    .in_valid    (mem_to_wb_valid),
    .own_allowin (wb_allowin),
    .out_valid   (retire_valid),
    .out_ready   (retire_ready),
    .payload     (retire)
);

bind mem_stage lsu_sva #(.PAYLOAD_W($bits(lsu_pkg::mem_payload_t))) u_mem_sva (
    .clk         (clk),
    .resetn      (resetn),
    .in_valid    (ex_to_mem_valid),
    .own_allowin (mem_allowin),
    .out_valid   (mem_to_wb_valid),
    .out_ready   (wb_allowin),
    .payload     (mem_to_wb_bus)
);

`default_nettype wire

//--- bench/tb_lsu_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lsu_top;
    import lsu_pkg::*;

    localparam int INIT_OPS   = 16;    // one word store per test word
    localparam int NUM_OPS    = INIT_OPS + 400;
    localparam int MAX_CYCLES = 8 * NUM_OPS + 100;

    logic    clk;
    logic    resetn;
    logic    in_valid;
    logic    in_allowin;
    ex_req_t in_req;
    logic    retire_valid;
    logic    retire_ready;
    retire_t retire;
    fwd_t    mem_fwd;
    fwd_t    wb_fwd;

    logic [DATA_W-1:0] model_mem [16];
    logic [DATA_W-1:0] model_csr [4];
    retire_t           exp_q [$];     // ops in flight, oldest first
    logic              csr_rd_q [$];  // same order, set for csr reads
    int                accepted = 0;
    int                retired = 0;
    int                full_seen = 0;
    int                cycles = 0;
    int                ready_left = 0;
    logic              took_last = 1'b0;   // an op was accepted at the previous edge

    lsu_top UUT (
        .clk          (clk),
        .resetn       (resetn),
        .in_valid     (in_valid),
        .in_allowin   (in_allowin),
        .in_req       (in_req),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire),
        .mem_fwd      (mem_fwd),
        .wb_fwd       (wb_fwd)
    );

    always #4 clk = ~clk;

    task automatic compare_values(input string what, input logic [127:0] got,
                                  input logic [127:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic is_save_csr(input logic [13:0] num);
        return num >= CSR_SAVE0 && num <= CSR_SAVE0 + 14'd3;
    endfunction

    // expected retire entry, rf_wdata zeroed when nothing is written
    function automatic retire_t expected_retire(input ex_req_t op);
        retire_t           r;
        logic [DATA_W-1:0] word;
        logic [DATA_W-1:0] lane;
        r.pc       = op.pc;
        r.rf_we    = op.rf_we && op.kind != op_store;
        r.rf_waddr = op.rf_waddr;
        word       = model_mem[op.alu_result[5:2]];
        lane       = word >> {op.alu_result[1:0], 3'b000};
        case (op.kind)
            op_load: begin
                case (op.size)
                    size_b:  r.rf_wdata = {{24{lane[7] & ~op.is_unsigned}}, lane[7:0]};
                    size_h:  r.rf_wdata = {{16{lane[15] & ~op.is_unsigned}}, lane[15:0]};
                    default: r.rf_wdata = word;
                endcase
            end
            op_csr:  r.rf_wdata = is_save_csr(op.csr_num) ? model_csr[op.csr_num[1:0]] : '0;
            default: r.rf_wdata = op.alu_result;
        endcase
        if (!r.rf_we) begin
            r.rf_wdata = '0;
        end
        return r;
    endfunction

    // memory and csr side effects in program order
    function automatic void apply_to_model(input ex_req_t op);
        logic [3:0]        w;
        logic [4:0]        sh;
        logic [DATA_W-1:0] keep;
        logic [DATA_W-1:0] old;
        w  = op.alu_result[5:2];
        sh = {op.alu_result[1:0], 3'b000};
        if (op.kind == op_store) begin
            case (op.size)
                size_b:  keep = ~(32'h0000_00ff << sh);
                size_h:  keep = ~(32'h0000_ffff << sh);
                default: keep = 32'h0;
            endcase
            model_mem[w] = (model_mem[w] & keep) | ((op.rkd_value << sh) & ~keep);
        end
        if (op.kind == op_csr && op.csr_we && is_save_csr(op.csr_num)) begin
            old = model_csr[op.csr_num[1:0]];
            model_csr[op.csr_num[1:0]] = (old & ~op.csr_wmask) | (op.rkd_value & op.csr_wmask);
        end
    endfunction

    function automatic ex_req_t init_store(input int n);
        ex_req_t op;
        op            = '0;
        op.pc         = 32'h1c00_0000 + n * 4;
        op.kind       = op_store;
        op.size       = size_w;
        op.alu_result = {26'h0, n[3:0], 2'b00};
        op.rkd_value  = $urandom;
        return op;
    endfunction

    function automatic ex_req_t random_op(input int n);
        ex_req_t     op;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [1:0]  off;
        r0 = $urandom;
        r1 = $urandom;
        op             = '0;
        op.pc          = 32'h1c00_0000 + n * 4;
        op.kind        = op_kind_e'(r0[1:0]);
        op.rf_we       = r0[2] | r0[3];
        op.rf_waddr    = r0[8:4];
        op.is_unsigned = r0[9];
        case (r0[11:10])
            2'd0:    op.size = size_b;
            2'd1:    op.size = size_h;
            default: op.size = size_w;
        endcase
        case (op.size)
            size_b:  off = r0[13:12];          // any byte offset
            size_h:  off = {r0[12], 1'b0};
            default: off = 2'b00;
        endcase
        if (op.kind == op_load || op.kind == op_store) begin
            op.alu_result = {r1[31:10], 4'h0, r0[17:14], off};   // 16 words only
        end else begin
            op.alu_result = r1;
        end
        op.rkd_value = $urandom;
        op.csr_num   = (r0[22:20] == 3'd0) ? r1[13:0] : {12'h00c, r0[19:18]};
        op.csr_we    = r0[23];
        op.csr_wmask = $urandom;
        return op;
    endfunction

    initial begin
        logic [31:0] r;
        void'($urandom(32'hb4e768c5));
        clk          = 1'b0;
        resetn       = 1'b0;
        in_valid     = 1'b0;
        in_req       = '0;
        retire_ready = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        compare_values("in_allowin after reset", 128'(in_allowin), 128'(1'b1));
        compare_values("retire_valid after reset", 128'(retire_valid), 128'(1'b0));
        compare_values("mem_fwd.we after reset", 128'(mem_fwd.we), 128'(1'b0));
        compare_values("wb_fwd.we after reset", 128'(wb_fwd.we), 128'(1'b0));
        for (int n = 0; n < NUM_OPS; n++) begin
            r = $urandom;
            if (n >= INIT_OPS && r[2:0] == 3'd0) begin
                in_valid = 1'b0;   // bubble
                @(negedge clk);
            end
            in_req   = (n < INIT_OPS) ? init_store(n) : random_op(n);
            in_valid = 1'b1;
            @(negedge clk);
            while (accepted <= n) begin
                @(negedge clk);
            end
        end
        in_valid = 1'b0;
        while (retired < NUM_OPS) begin
            @(negedge clk);
        end
        repeat (5) @(negedge clk);   // catch late duplicates
        compare_values("pipeline filled under back-pressure", 128'(full_seen > 0), 128'(1'b1));
        $display("Simulation completed successfully");
        $finish;
    end

    // retire_ready in random stretches, low ones included
    always @(negedge clk) begin
        logic [31:0] r;
        if (resetn) begin
            if (ready_left == 0) begin
                r            = $urandom;
                retire_ready = r[0] | r[1];
                ready_left   = 1 + r[4:2];
            end
            ready_left--;
        end
    end

    always @(posedge clk) begin
        retire_t exp;
        retire_t got;
        int      slot;
        int      behind;
        logic    mem_full;
        if (resetn) begin
            compare_values("in_allowin", 128'(in_allowin),
                           128'(exp_q.size() < 3 || retire_ready));
            if (exp_q.size() == 3 && !retire_ready) begin
                full_seen++;
            end
            slot   = retire_valid ? 1 : 0;   // mem op sits behind the wb op
            behind = exp_q.size() - slot;
            // a lone op behind wb is still in ex if it was taken at the last edge
            mem_full = behind == 2 || (behind == 1 && !took_last);
            compare_values("mem_fwd.we", 128'(mem_fwd.we),
                           128'(mem_full && exp_q[slot].rf_we));
            if (mem_fwd.we) begin
                compare_values("mem_fwd.waddr", 128'(mem_fwd.waddr), 128'(exp_q[slot].rf_waddr));
                compare_values("mem_fwd.csr_pending", 128'(mem_fwd.csr_pending),
                               128'(csr_rd_q[slot]));
                if (!csr_rd_q[slot]) begin
                    compare_values("mem_fwd.wdata", 128'(mem_fwd.wdata),
                                   128'(exp_q[slot].rf_wdata));
                end
            end else begin
                compare_values("mem_fwd.csr_pending", 128'(mem_fwd.csr_pending), 128'(1'b0));
            end
            compare_values("wb_fwd.csr_pending", 128'(wb_fwd.csr_pending), 128'(1'b0));
            if (retire_valid) begin
                compare_values("retire with nothing in flight", 128'(exp_q.size() > 0),
                               128'(1'b1));
                compare_values("wb_fwd.we", 128'(wb_fwd.we), 128'(exp_q[0].rf_we));
                if (exp_q[0].rf_we) begin
                    compare_values("wb_fwd.waddr", 128'(wb_fwd.waddr), 128'(exp_q[0].rf_waddr));
                    compare_values("wb_fwd.wdata", 128'(wb_fwd.wdata), 128'(exp_q[0].rf_wdata));
                end
                if (retire_ready) begin
                    got = retire;
                    if (!got.rf_we) begin
                        got.rf_wdata = '0;
                    end
                    compare_values("retire", 128'(got), 128'(exp_q[0]));
                    void'(exp_q.pop_front());
                    void'(csr_rd_q.pop_front());
                    retired++;
                end
            end else begin
                compare_values("wb_fwd.we", 128'(wb_fwd.we), 128'(1'b0));
            end
            if (in_valid && in_allowin) begin
                exp = expected_retire(in_req);
                apply_to_model(in_req);
                exp_q.push_back(exp);
                csr_rd_q.push_back(in_req.kind == op_csr && in_req.rf_we);
                accepted++;
            end
            took_last = in_valid && in_allowin;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("ERROR: timeout after %0d cycles, %0d of %0d operations retired",
                     cycles, retired, NUM_OPS);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

//--- compile.f
hdl/lsu_pkg.sv
hdl/load_extract.sv
hdl/data_sram.sv
hdl/ex_issue_stage.sv
hdl/mem_stage.sv
hdl/wb_stage.sv
hdl/lsu_top.sv
bench/lsu_sva.sv
bench/tb_lsu_top.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_lsu_top -f compile.f -o tb_lsu_top \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_lsu_top > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0
